//--- hdl/host_bridge_pkg.sv
package host_bridge_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [7:0]        opcode_t;
  typedef logic [15:0]       len_t;

  localparam opcode_t OP_ECHO   = 8'h01;
  localparam opcode_t OP_INVERT = 8'h02;
  localparam opcode_t OP_SUM    = 8'h03;

  localparam int WR_DEPTH = 16;  // host -> engine
  localparam int RD_DEPTH = 16;  // engine -> host

  localparam word_t CLOSE_WORD = '1;  // all-ones header ends the session

  typedef struct packed {
    opcode_t     opcode;  // bits 31:24
    logic [7:0]  spare;   // ignored
    len_t        length;  // payload words following
  } header_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } push_t;

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_PAYLOAD,
    ST_SUM_OUT,
    ST_CLOSED
  } engine_state_e;

  typedef enum logic [1:0] {
    SEL_PASS,
    SEL_INVERT,
    SEL_SUM
  } reply_sel_e;

endpackage

//--- hdl/stream_fifo.sv
module stream_fifo import host_bridge_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  logic  bus_clk,
  input  logic  rst,
  input  push_t push,
  input  logic  pop,
  output word_t head,
  output logic  empty,
  output logic  full,
  output logic  overflow
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;
  logic             pop_ok;

  assign push_ok = push.valid && !full;
  assign pop_ok  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign head  = mem[rd_ptr];  // fall-through view

  always_ff @(posedge bus_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push.data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= push.valid && full;  // dropped write
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or simultaneous
      endcase
    end
  end

  // an empty buffer has both pointers on the same slot
  a_empty_ptrs: assert property (
    @(posedge bus_clk) disable iff (rst)
    empty |-> (rd_ptr == wr_ptr)
  ) else $error("stream_fifo: pointers apart while empty");

  a_count_bound: assert property (
    @(posedge bus_clk) disable iff (rst)
    count <= CNT_W'(DEPTH)
  ) else $error("stream_fifo: occupancy above depth");

endmodule

//--- hdl/word_counter.sv
module word_counter import host_bridge_pkg::*; (
  input  logic bus_clk,
  input  logic rst,
  input  logic load,
  input  len_t length,
  input  logic dec,
  output logic done
);

  // words still due after the one at the fifo head
  len_t remaining;

  assign done = (remaining == '0);

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= length;
    end else if (dec) begin
      remaining <= remaining - 1'b1;
    end
  end

  // a decrement at zero would wrap and stretch the packet
  a_no_dec_done: assert property (
    @(posedge bus_clk) disable iff (rst)
    dec |-> !done
  ) else $error("word_counter: decrement with count at zero");

endmodule

//--- hdl/reply_datapath.sv
module reply_datapath import host_bridge_pkg::*; (
  input  logic       bus_clk,
  input  logic       rst,
  input  word_t      word,
  input  reply_sel_e sel,
  input  logic       sum_clr,
  input  logic       sum_acc,
  output word_t      reply_word
);

  word_t sum_q;

  // running modulo-2^32 sum of the current packet
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      sum_q <= '0;
    end else if (sum_clr) begin
      sum_q <= '0;
    end else if (sum_acc) begin
      sum_q <= sum_q + word;  // wraps naturally
    end
  end

  always_comb begin
    case (sel)
      SEL_PASS:   reply_word = word;
      SEL_INVERT: reply_word = ~word;
      SEL_SUM:    reply_word = sum_q;
      default:    reply_word = word;
    endcase
  end

  // clear and accumulate come from different states of the engine
  a_clr_acc_excl: assert property (
    @(posedge bus_clk) disable iff (rst)
    !(sum_clr && sum_acc)
  ) else $error("reply_datapath: sum cleared and accumulated together");

endmodule

//--- hdl/msg_engine_fsm.sv
module msg_engine_fsm import host_bridge_pkg::*; (
  input  logic       bus_clk,
  input  logic       rst,
  input  word_t      in_data,
  input  logic       in_empty,
  output logic       in_pop,
  input  logic       out_full,
  input  logic       out_empty,
  output logic       cnt_load,
  output len_t       cnt_len,
  output logic       cnt_dec,
  input  logic       cnt_done,
  output reply_sel_e sel,
  output logic       sum_clr,
  output logic       sum_acc,
  input  word_t      reply_word,
  output push_t      reply,
  output logic       eof
);

  engine_state_e state;
  engine_state_e state_nxt;
  opcode_t       op;       // opcode of the packet in flight
  header_t       hdr;
  logic          is_close;
  logic          hdr_pop;
  logic          pay_pop;
  logic          pass_op;  // echo or invert, one reply per word

  assign hdr      = header_t'(in_data);
  assign is_close = (in_data == CLOSE_WORD);
  assign hdr_pop  = (state == ST_HEADER) && !in_empty;
  assign pay_pop  = (state == ST_PAYLOAD) && !in_empty && !out_full;
  assign pass_op  = (op == OP_ECHO) || (op == OP_INVERT);

  assign in_pop   = hdr_pop || pay_pop;

  // counter holds words left after the head, so done marks the last one
  assign cnt_load = hdr_pop && !is_close;
  assign cnt_len  = (hdr.length == '0) ? '0 : hdr.length - 1'b1;
  assign cnt_dec  = pay_pop && !cnt_done;

  assign sum_clr  = cnt_load;
  assign sum_acc  = pay_pop && (op == OP_SUM);

  always_comb begin
    if (state == ST_SUM_OUT) begin
      sel = SEL_SUM;
    end else if (op == OP_INVERT) begin
      sel = SEL_INVERT;
    end else begin
      sel = SEL_PASS;  // unknown opcodes never push
    end
  end

  assign reply.valid = (pay_pop && pass_op) || ((state == ST_SUM_OUT) && !out_full);
  assign reply.data  = reply_word;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_HEADER: begin
        if (hdr_pop) begin
          if (is_close) begin
            state_nxt = ST_CLOSED;
          end else if (hdr.length != '0) begin
            state_nxt = ST_PAYLOAD;
          end else if (hdr.opcode == OP_SUM) begin
            state_nxt = ST_SUM_OUT;  // empty sum still answers 0
          end
        end
      end
      ST_PAYLOAD: begin
        if (pay_pop && cnt_done) begin
          state_nxt = (op == OP_SUM) ? ST_SUM_OUT : ST_HEADER;
        end
      end
      ST_SUM_OUT: begin
        if (!out_full) begin
          state_nxt = ST_HEADER;
        end
      end
      ST_CLOSED: state_nxt = ST_CLOSED;  // terminal
      default:   state_nxt = ST_HEADER;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      state <= ST_HEADER;
      op    <= '0;
      eof   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (cnt_load) begin
        op <= hdr.opcode;
      end
      if ((state == ST_CLOSED) && out_empty) begin
        eof <= 1'b1;  // sticky
      end
    end
  end

  a_no_pop_empty: assert property (
    @(posedge bus_clk) disable iff (rst)
    in_pop |-> !in_empty
  ) else $error("msg_engine_fsm: pop with input fifo empty");

  // no reply may be left for the host once eof is up
  a_eof_drained: assert property (
    @(posedge bus_clk) disable iff (rst)
    eof |-> out_empty
  ) else $error("msg_engine_fsm: eof with replies pending");

endmodule

//--- hdl/host_bridge_top.sv
module host_bridge_top import host_bridge_pkg::*; (
  input  logic  bus_clk,
  input  logic  rst,
  input  push_t wr,
  output logic  wr_full,
  output logic  wr_overflow,
  input  logic  rd_en,
  output word_t rd_data,
  output logic  rd_empty,
  output logic  eof
);

  word_t      in_data;
  logic       in_empty;
  logic       in_pop;
  logic       out_full;
  logic       cnt_load;
  len_t       cnt_len;
  logic       cnt_dec;
  logic       cnt_done;
  reply_sel_e sel;
  logic       sum_clr;
  logic       sum_acc;
  word_t      reply_word;
  push_t      reply;

  stream_fifo #(.DEPTH(WR_DEPTH)) in_fifo (
    .bus_clk(bus_clk), .rst(rst),
    .push(wr), .pop(in_pop),
    .head(in_data), .empty(in_empty),
    .full(wr_full), .overflow(wr_overflow)
  );

  msg_engine_fsm engine (
    .bus_clk(bus_clk), .rst(rst),
    .in_data(in_data), .in_empty(in_empty), .in_pop(in_pop),
    .out_full(out_full), .out_empty(rd_empty),
    .cnt_load(cnt_load), .cnt_len(cnt_len), .cnt_dec(cnt_dec), .cnt_done(cnt_done),
    .sel(sel), .sum_clr(sum_clr), .sum_acc(sum_acc), .reply_word(reply_word),
    .reply(reply), .eof(eof)
  );

  word_counter counter (
    .bus_clk(bus_clk), .rst(rst),
    .load(cnt_load), .length(cnt_len), .dec(cnt_dec), .done(cnt_done)
  );

  reply_datapath datapath (
    .bus_clk(bus_clk), .rst(rst),
    .word(in_data), .sel(sel), .sum_clr(sum_clr), .sum_acc(sum_acc),
    .reply_word(reply_word)
  );

  // engine never pushes while full, so overflow stays unused here
  stream_fifo #(.DEPTH(RD_DEPTH)) out_fifo (
    .bus_clk(bus_clk), .rst(rst),
    .push(reply), .pop(rd_en),
    .head(rd_data), .empty(rd_empty),
    .full(out_full), .overflow()
  );

endmodule

//--- tests/tb_host_bridge.sv
module tb_host_bridge import host_bridge_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  typedef word_t word_q_t[$];

  logic    bus_clk = 1'b0;
  logic    rst;
  push_t   wr;
  logic    wr_full;
  logic    wr_overflow;
  logic    rd_en;
  word_t   rd_data;
  logic    rd_empty;
  logic    eof;

  word_q_t exp_q;           // replies not yet read
  logic    reads_on;
  int      errors = 0;
  int      errs_at_start;
  int      tests_ok = 0;
  int      tests_bad = 0;
  int      test_num = 0;
  int      ovf_pulses = 0;
  int      words_sent = 0;
  int      cycles = 0;

  host_bridge_top dut0 (
    .bus_clk(bus_clk), .rst(rst),
    .wr(wr), .wr_full(wr_full), .wr_overflow(wr_overflow),
    .rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty), .eof(eof)
  );

  always #2 bus_clk = ~bus_clk;  // 4 ns period

  // expected reply words for one packet
  function automatic word_q_t expected_reply(input opcode_t op, input word_q_t payload);
    word_q_t r;
    word_t   acc;
    acc = '0;
    foreach (payload[i]) begin
      case (op)
        OP_ECHO:   r.push_back(payload[i]);
        OP_INVERT: r.push_back(~payload[i]);
        OP_SUM:    acc = acc + payload[i];  // wraps at 2^32
        default:   ;  // unknown opcode, dropped
      endcase
    end
    if (op == OP_SUM) begin
      r.push_back(acc);
    end
    return r;
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_eof(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error %0t: %s eof is %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pulses(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("Error %0t: %s saw %0d overflow pulses expected %0d", $time, what, got, exp);
    end
  endtask

  // one accepted word per call, waits out wr_full
  task automatic write_word(input word_t w);
    @(negedge bus_clk);
    while (wr_full) begin
      wr <= '0;
      @(negedge bus_clk);
    end
    wr <= '{valid: 1'b1, data: w};
    words_sent++;
  endtask

  task automatic release_bus();
    @(negedge bus_clk);
    wr <= '0;
  endtask

  task automatic send_packet(input opcode_t op, input int len);
    word_q_t payload;
    header_t hdr;
    for (int i = 0; i < len; i++) begin
      payload.push_back($urandom);
    end
    exp_q = {exp_q, expected_reply(op, payload)};
    hdr.opcode = op;
    hdr.spare  = 8'($urandom);
    hdr.length = len_t'(len);
    write_word(word_t'(hdr));
    foreach (payload[i]) begin
      write_word(payload[i]);
    end
    release_bus();
  endtask

  task automatic start_test();
    test_num++;
    errs_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    while (exp_q.size() != 0 || !rd_empty) begin
      @(negedge bus_clk);
    end
    repeat (8) @(negedge bus_clk);  // let stray replies show up
    if (errors == errs_at_start) begin
      tests_ok++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", test_num, name, errors - errs_at_start);
    end
  endtask

  // reader, pops at random while data is there
  always @(negedge bus_clk) begin
    if (rst || !reads_on || rd_empty || ($urandom % 4 == 0)) begin
      rd_en <= 1'b0;
    end else begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error %0t: unexpected reply word %h", $time, rd_data);
      end else begin
        check_word(rd_data, exp_q.pop_front(), "reply");
      end
      rd_en <= 1'b1;
    end
  end

  always @(posedge bus_clk) begin
    if (!rst && wr_overflow) begin
      ovf_pulses++;
    end
  end

  always @(posedge bus_clk) begin
    cycles++;
    if (cycles > 40 * words_sent + 2000) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    word_q_t payload;
    int      i;
    void'($urandom(32'h137b_e798));
    wr       = '0;
    rd_en    = 1'b0;
    rst      = 1'b1;
    reads_on = 1'b1;
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    rst = 1'b0;

    start_test();
    repeat (8) send_packet(OP_ECHO, $urandom_range(20, 1));
    finish_test("echo");

    start_test();
    repeat (8) send_packet(OP_INVERT, $urandom_range(20, 1));
    finish_test("invert");

    start_test();
    repeat (6) send_packet(OP_SUM, $urandom_range(20, 1));
    send_packet(OP_SUM, 0);  // empty sum answers 0
    finish_test("sum");

    start_test();
    send_packet(8'h5a, 7);
    send_packet(OP_ECHO, 4);
    send_packet(8'h00, 0);
    send_packet(OP_SUM, 5);
    send_packet(8'hc3, 12);
    send_packet(OP_INVERT, 3);
    finish_test("unknown opcode");

    start_test();
    reads_on = 1'b0;
    for (i = 0; i < 40; i++) begin
      payload.push_back($urandom);
    end
    exp_q = {exp_q, expected_reply(OP_ECHO, payload)};
    write_word({OP_ECHO, 8'h00, 16'd40});
    for (i = 0; i < 32; i++) begin
      write_word(payload[i]);  // fills both fifos
    end
    release_bus();
    while (!wr_full) begin
      @(negedge bus_clk);
    end
    check_pulses(ovf_pulses, 0, "writer respecting full");
    wr <= '{valid: 1'b1, data: 32'hdead_beef};  // deliberate write while full
    @(negedge bus_clk);
    wr <= '0;
    @(negedge bus_clk);
    check_pulses(ovf_pulses, 1, "write while full");
    reads_on = 1'b1;
    for (i = 32; i < 40; i++) begin
      write_word(payload[i]);
    end
    release_bus();
    check_pulses(ovf_pulses, 1, "writes after resume");
    finish_test("back-pressure");

    start_test();
    reads_on = 1'b0;
    send_packet(OP_INVERT, 3);
    write_word(CLOSE_WORD);
    write_word($urandom);  // ignored after close
    write_word($urandom);
    release_bus();
    while (rd_empty) begin
      @(negedge bus_clk);
    end
    repeat (20) @(negedge bus_clk);
    check_eof(eof, 1'b0, "replies unread");
    reads_on = 1'b1;
    while (exp_q.size() != 0 || !rd_empty) begin
      @(negedge bus_clk);
    end
    for (i = 0; i < 8 && !eof; i++) begin
      @(negedge bus_clk);
    end
    check_eof(eof, 1'b1, "all replies read");
    finish_test("close and eof");

    $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- host_bridge.f
hdl/host_bridge_pkg.sv
hdl/stream_fifo.sv
hdl/word_counter.sv
hdl/reply_datapath.sv
hdl/msg_engine_fsm.sv
hdl/host_bridge_top.sv
tests/tb_host_bridge.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_host_bridge -o sim_tb \
  -f host_bridge.f

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
